//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_calc_top
FILELIST = build.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# a $fatal in the testbench makes the binary exit non-zero
run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- build.f
+incdir+include
src/calc_pkg.sv
src/key_if.sv
src/keypad_scanner.sv
src/calc_engine.sv
src/calc_top.sv
test/tb_calc_top.sv

//--- include/calc_keys.svh
`ifndef CALC_KEYS_SVH
`define CALC_KEYS_SVH

// keypad position is row * 4 + col
//   col   0  1  2  3
//   row0  1  2  3  add
//   row1  4  5  6  sub
//   row2  7  8  9  mul
//   row3  =  0  C  +/-
// expects calc_pkg to be imported where these expand

`define KEY_POS_IS_DIGIT(p) \
    ((p) != 4'd3 && (p) != 4'd7 && (p) != 4'd11 && \
     (p) != 4'd12 && (p) != 4'd14 && (p) != 4'd15)

`define KEY_POS_DIGIT(p) \
    ((p) == 4'd13 ? 4'd0 : 4'((((p) >> 2) * 3) + ((p) & 4'd3) + 1))

`define KEY_POS_OP(p) \
    op_t'((p) == 4'd3 ? OP_ADD : (p) == 4'd7 ? OP_SUB : \
          (p) == 4'd11 ? OP_MUL : (p) == 4'd15 ? OP_NEG : OP_NONE)

`define KEY_POS_KIND(p) \
    key_kind_t'((p) == 4'd12 ? KEY_EQUAL : (p) == 4'd14 ? KEY_CLEAR : \
                `KEY_POS_IS_DIGIT(p) ? KEY_DIGIT : KEY_OP)

`endif

//--- src/calc_engine.sv
`timescale 1ns/100ps

module calc_engine import calc_pkg::*; #(
    parameter int WIDTH = 16                  // data width, wraps two's complement
) (
    input  logic             clk,
    input  logic             nRST,
    key_if.sink              key,
    output logic [WIDTH-1:0] display,
    output logic             busy             // high while multiplying
);

    localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    typedef enum logic {
        IDLE,                                 // accepts keys
        MULTIPLY                              // shift-add loop, keys wait
    } eng_state_t;

    eng_state_t       state;
    op_t              pending;                // operator waiting for next entry
    logic [WIDTH-1:0] entry;                  // number being typed
    logic [WIDTH-1:0] acc;                    // running result
    logic [WIDTH-1:0] combined;               // acc <pending> entry, non-mul
    logic [WIDTH-1:0] digit_entry;            // entry*10 + digit
    logic [WIDTH-1:0] mcand;                  // shifted left each step
    logic [WIDTH-1:0] mplier;                 // shifted right each step
    logic [WIDTH-1:0] product;
    logic [WIDTH-1:0] product_next;
    logic [CNT_W-1:0] bit_cnt;                // multiply step
    logic             take;                   // transfer on this edge
    logic             is_combine;             // add/sub/mul/equal key
    logic             start_mul;
    logic             mul_last;

    assign take          = key.key_ready && (state == IDLE);
    assign key.key_taken = take;
    assign busy          = (state == MULTIPLY);

    assign is_combine = (key.kind == KEY_EQUAL) ||
                        (key.kind == KEY_OP && key.op != OP_NEG);
    assign start_mul  = take && is_combine && (pending == OP_MUL);
    assign mul_last   = (bit_cnt == CNT_W'(WIDTH - 1));

    // x10 as x8 + x2
    assign digit_entry  = (entry << 3) + (entry << 1) + {{(WIDTH-4){1'b0}}, key.digit};
    assign product_next = mplier[0] ? product + mcand : product;

    always_comb begin
        case (pending)
            OP_ADD:  combined = acc + entry;
            OP_SUB:  combined = acc - entry;
            default: combined = entry;        // OP_NONE just loads
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state   <= IDLE;
            pending <= OP_NONE;
            entry   <= '0;
            acc     <= '0;
            display <= '0;
            bit_cnt <= '0;
        end else if (state == MULTIPLY) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (mul_last) begin
                acc     <= product_next;      // final partial sum folded in
                display <= product_next;
                state   <= IDLE;
            end
        end else if (take) begin
            case (key.kind)
                KEY_DIGIT: begin
                    entry   <= digit_entry;
                    display <= digit_entry;
                end
                KEY_CLEAR: begin
                    entry   <= '0;
                    acc     <= '0;
                    display <= '0;
                    pending <= OP_NONE;
                end
                default: begin
                    if (is_combine) begin
                        entry <= '0;
                        // equal leaves nothing pending
                        if (key.kind == KEY_EQUAL) begin
                            pending <= OP_NONE;
                        end else begin
                            pending <= key.op;
                        end
                        if (pending == OP_MUL) begin
                            state   <= MULTIPLY;  // display waits for product
                            bit_cnt <= '0;
                        end else begin
                            acc     <= combined;
                            display <= combined;
                        end
                    end else begin
                        entry   <= -entry;    // change sign
                        display <= -entry;
                    end
                end
            endcase
        end
    end

    // shift-add datapath
    always_ff @(posedge clk) begin
        if (start_mul) begin
            mcand   <= acc;
            mplier  <= entry;
            product <= '0;
        end else if (state == MULTIPLY) begin
            product <= product_next;
            mcand   <= mcand << 1;
            mplier  <= mplier >> 1;
        end
    end

endmodule

//--- src/calc_pkg.sv
package calc_pkg;

    // what the presented key means
    typedef enum logic [1:0] {
        KEY_DIGIT,                  // 0..9 in digit field
        KEY_OP,                     // operator in op field, incl. change sign
        KEY_EQUAL,                  // finish pending op
        KEY_CLEAR                   // reset everything
    } key_kind_t;

    // operator codes, same numbering as the keypad encoder
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,             // nothing pending, load entry
        OP_NEG  = 3'd1,             // change sign of entry
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4              // multi-cycle shift-add
    } op_t;

endpackage

//--- src/calc_top.sv
`timescale 1ns/100ps

module calc_top #(
    parameter int WIDTH           = 16,   // entry/acc/display width
    parameter int DEBOUNCE_CYCLES = 10    // stable-low cycles per press
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic [3:0]       rows,        // keypad rows, pulled up
    output logic [3:0]       cols,        // keypad columns, one low
    output logic [WIDTH-1:0] display,
    output logic             busy         // multiply in progress
);

    key_if key_bus ();                    // scanner -> engine key handshake

    keypad_scanner #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) scanner_i (
        .clk  (clk),
        .nRST (nRST),
        .rows (rows),
        .cols (cols),
        .key  (key_bus.source)
    );

    calc_engine #(
        .WIDTH (WIDTH)
    ) engine_i (
        .clk     (clk),
        .nRST    (nRST),
        .key     (key_bus.sink),
        .display (display),
        .busy    (busy)
    );

endmodule

//--- src/key_if.sv
`timescale 1ns/100ps

interface key_if import calc_pkg::*; ();

    logic      key_ready;           // key valid, held until taken
    logic      key_taken;           // engine accepts on this edge
    key_kind_t kind;                // meaning of key
    logic [3:0] digit;              // only for KEY_DIGIT
    op_t       op;                  // only for KEY_OP

    // scanner side
    modport source (
        output key_ready,
        output kind,
        output digit,
        output op,
        input  key_taken
    );

    // engine side
    modport sink (
        input  key_ready,
        input  kind,
        input  digit,
        input  op,
        output key_taken
    );

endinterface

//--- src/keypad_scanner.sv
`timescale 1ns/100ps
`include "calc_keys.svh"

module keypad_scanner import calc_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = 10        // stable-low cycles before a key counts
) (
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] rows,                  // pulled up, low = pressed
    output logic [3:0] cols,                  // exactly one column low
    key_if.source      key
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    typedef enum logic [1:0] {
        SCAN_COL,                             // walk columns, look for a low row
        DEBOUNCE,                             // row must stay low
        PRESENT,                              // key_ready up, wait for key_taken
        WAIT_RELEASE                          // one key per press
    } scan_state_t;

    scan_state_t      state;
    logic [1:0]       col_idx;                // column being driven low
    logic [CNT_W-1:0] db_cnt;                 // stable cycles so far
    logic             any_low;                // some row pulled low
    logic             db_done;                // last debounce cycle
    logic [3:0]       key_pos;                // row*4 + col of pressed key

    // lowest pressed row wins
    function automatic logic [3:0] encode_pos(input logic [3:0] row_n,
                                              input logic [1:0] col);
        logic [1:0] hit;
        hit = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (!row_n[r]) begin
                hit = 2'(r);
            end
        end
        return {hit, col};                    // == hit*4 + col
    endfunction

    assign any_low = ~&rows;
    assign db_done = any_low && (db_cnt == CNT_W'(DEBOUNCE_CYCLES - 1));
    assign key_pos = encode_pos(rows, col_idx);

    // one-cold column drive
    always_comb begin
        cols = 4'b1111;
        cols[col_idx] = 1'b0;
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state         <= SCAN_COL;
            col_idx       <= 2'd0;            // cols = 1110
            db_cnt        <= '0;
            key.key_ready <= 1'b0;
        end else begin
            case (state)
                SCAN_COL: begin
                    db_cnt <= '0;
                    if (any_low) begin
                        state <= DEBOUNCE;    // hold column on the hit
                    end else begin
                        col_idx <= col_idx + 2'd1;
                    end
                end
                DEBOUNCE: begin
                    if (!any_low) begin
                        state  <= SCAN_COL;   // bounce, start over
                        db_cnt <= '0;
                    end else if (db_done) begin
                        state         <= PRESENT;
                        key.key_ready <= 1'b1;    // payload latched same edge
                    end else begin
                        db_cnt <= db_cnt + 1'b1;
                    end
                end
                PRESENT: begin
                    // engine may stall here while multiplying
                    if (key.key_taken) begin
                        state         <= WAIT_RELEASE;
                        key.key_ready <= 1'b0;
                    end
                end
                WAIT_RELEASE: begin
                    if (!any_low) begin
                        state <= SCAN_COL;    // all rows high again
                    end
                end
                default: begin
                    state <= SCAN_COL;
                end
            endcase
        end
    end

    // key payload, decoded through the shared table
    always_ff @(posedge clk) begin
        if (state == DEBOUNCE && db_done) begin
            key.kind  <= `KEY_POS_KIND(key_pos);
            key.digit <= `KEY_POS_DIGIT(key_pos);
            key.op    <= `KEY_POS_OP(key_pos);
        end
    end

endmodule

//--- test/tb_calc_top.sv
`timescale 1ns/100ps
`include "calc_keys.svh"

module tb_calc_top import calc_pkg::*; ();

    localparam int WIDTH         = 16;
    localparam int N_DIRECTED    = 36;                   // presses in the directed part
    localparam int N_RANDOM      = 300;
    localparam int TOTAL_PRESSES = N_DIRECTED + N_RANDOM;
    localparam logic [3:0] K_ADD = 4'd3;
    localparam logic [3:0] K_SUB = 4'd7;
    localparam logic [3:0] K_MUL = 4'd11;
    localparam logic [3:0] K_EQ  = 4'd12;
    localparam logic [3:0] K_CLR = 4'd14;
    localparam logic [3:0] K_NEG = 4'd15;

    logic             clk;
    logic             nRST;
    logic [3:0]       rows;
    logic [3:0]       cols;
    logic [WIDTH-1:0] display;
    logic             busy;
    logic             pressed;                           // keypad model: a key is down
    logic [3:0]       press_pos;                         // row*4 + col of that key
    logic [WIDTH-1:0] m_entry;                           // reference model state
    logic [WIDTH-1:0] m_acc;
    logic [WIDTH-1:0] m_display;
    op_t              m_pending;
    int               seed;

    calc_top #(
        .WIDTH           (WIDTH),
        .DEBOUNCE_CYCLES (10)
    ) dut_i (
        .clk     (clk),
        .nRST    (nRST),
        .rows    (rows),
        .cols    (cols),
        .display (display),
        .busy    (busy)
    );

    always #50 clk = ~clk;                               // 100 ns period

    // switch matrix, row pulled low only while its column is driven low
    assign rows = (pressed && !cols[press_pos[1:0]]) ? ~(4'b0001 << press_pos[3:2]) : 4'b1111;

    task automatic next_drive();
        @(posedge clk);
        #10;                                             // stimulus point after the edge
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %0d (0x%0h), actual %0d (0x%0h)",
                     name, expected, expected, actual, actual);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // find the key position of a digit through the shared table
    function automatic logic [3:0] pos_for_digit(input int d);
        logic [3:0] pos;
        pos = 4'd0;
        for (int p = 0; p < 16; p++) begin
            if (`KEY_POS_IS_DIGIT(4'(p)) && (`KEY_POS_DIGIT(4'(p)) == 4'(d))) begin
                pos = 4'(p);
            end
        end
        return pos;
    endfunction

    // calculator rules applied to one press
    task automatic model_key(input logic [3:0] pos);
        key_kind_t        kind;
        op_t              op;
        logic [WIDTH-1:0] result;
        kind = `KEY_POS_KIND(pos);
        op   = `KEY_POS_OP(pos);
        if (kind == KEY_DIGIT) begin
            m_entry   = m_entry * WIDTH'(10) + WIDTH'(`KEY_POS_DIGIT(pos));  // wraps
            m_display = m_entry;
        end else if (kind == KEY_CLEAR) begin
            m_entry   = '0;
            m_acc     = '0;
            m_display = '0;
            m_pending = OP_NONE;
        end else if (kind == KEY_OP && op == OP_NEG) begin
            m_entry   = -m_entry;
            m_display = m_entry;
        end else begin
            case (m_pending)
                OP_ADD:  result = m_acc + m_entry;
                OP_SUB:  result = m_acc - m_entry;
                OP_MUL:  result = m_acc * m_entry;   // low WIDTH bits of product
                default: result = m_entry;
            endcase
            m_acc     = result;
            m_display = result;
            m_entry   = '0;
            m_pending = (kind == KEY_EQUAL) ? OP_NONE : op;
        end
    endtask

    task automatic press_key(input logic [3:0] pos, input int hold, input int rel);
        model_key(pos);
        press_pos = pos;
        pressed   = 1'b1;
        repeat (hold) next_drive();
        pressed = 1'b0;
        repeat (rel) next_drive();                       // all rows high again
    endtask

    task automatic check_display(input string name);
        while (busy) begin
            next_drive();                                // multiply still running
        end
        check_equal(name, 32'(m_display), 32'(display));
    endtask

    task automatic tap(input logic [3:0] pos, input string name);
        press_key(pos, 25, 20);
        check_display(name);
    endtask

    initial begin
        repeat (TOTAL_PRESSES * 200) @(posedge clk);
        $display("watchdog timeout: key sequence did not finish within %0d cycles",
                 TOTAL_PRESSES * 200);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        int               r;
        int               hold;
        int               rel;
        logic [3:0]       pos;
        clk       = 1'b0;
        nRST      = 1'b0;
        pressed   = 1'b0;
        press_pos = 4'd0;
        m_entry   = '0;
        m_acc     = '0;
        m_display = '0;
        m_pending = OP_NONE;
        seed      = 32'h4682_169b;
        repeat (5) @(posedge clk);
        #10;
        check_equal("reset cols", 32'(4'b1110), 32'(cols));
        check_equal("reset display", 32'd0, 32'(display));
        check_equal("reset busy", 32'd0, 32'(busy));
        nRST = 1'b1;
        repeat (2) next_drive();
        // digit entry, one long hold, then wrap
        tap(pos_for_digit(1), "digit 1");
        tap(pos_for_digit(2), "digit 12");
        tap(pos_for_digit(3), "digit 123");
        press_key(pos_for_digit(4), 200, 20);            // held long, counts once
        check_display("long hold 4");
        tap(pos_for_digit(9), "digit wrap a");
        tap(pos_for_digit(9), "digit wrap b");
        tap(pos_for_digit(5), "digit wrap c");
        tap(K_CLR, "clear after digits");
        // add and subtract chain
        tap(pos_for_digit(4), "chain 4");
        tap(pos_for_digit(5), "chain 45");
        tap(K_ADD, "chain add");
        tap(pos_for_digit(1), "chain 1");
        tap(pos_for_digit(2), "chain 12");
        tap(K_SUB, "chain sub");
        tap(pos_for_digit(7), "chain 7");
        tap(K_EQ, "chain equal");
        tap(pos_for_digit(8), "neg 8");
        tap(K_NEG, "neg negate");
        tap(K_ADD, "neg add");
        tap(pos_for_digit(3), "neg 3");
        tap(K_EQ, "neg equal");
        tap(K_CLR, "clear after chain");
        // multiply, next key pressed while busy
        tap(pos_for_digit(1), "mul 1");
        tap(pos_for_digit(2), "mul 12");
        tap(K_MUL, "mul op");
        tap(pos_for_digit(3), "mul 3");
        tap(pos_for_digit(4), "mul 34");
        press_key(K_EQ, 15, 1);                          // next key ready before product
        check_equal("mul busy at next press", 32'd1, 32'(busy));
        tap(pos_for_digit(7), "key during busy");
        tap(K_MUL, "mul op again");
        tap(pos_for_digit(3), "mul 3 again");
        tap(K_SUB, "mul product");                       // leaves subtract pending
        // clear with an operator pending, then fresh start
        tap(K_CLR, "clear");
        tap(pos_for_digit(5), "fresh 5");
        tap(pos_for_digit(2), "fresh 52");
        tap(K_EQ, "fresh equal");
        // random presses over all positions
        for (int i = 0; i < N_RANDOM; i++) begin
            r    = $random(seed);
            pos  = r[3:0];
            r    = $random(seed);
            hold = 20 + ((r & 32'h7fff_ffff) % 41);
            r    = $random(seed);
            rel  = 15 + ((r & 32'h7fff_ffff) % 26);
            press_key(pos, hold, rel);
            check_display($sformatf("random press %0d pos %0d", i, pos));
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule
